/* Makefile */
SHELL    = /bin/bash
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = dac_chain_tb
FILELIST = sim.f

BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(FILELIST) $(wildcard verilog/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	set -o pipefail; ./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

/* sim.f */
+incdir+tests
verilog/dac_chain_pkg.sv
verilog/dac_cmd_ctrl.sv
verilog/dac_ramp_source.sv
verilog/dac_prescaler.sv
verilog/dac_output_chain.sv
tests/dac_chain_tb.sv

/* tests/dac_chain_model.svh */
/* Reference model of the chain, included inside the testbench module. A commit is
   modeled as instant, so the stream must be idle around every commit */
`ifndef DAC_CHAIN_MODEL_SVH
`define DAC_CHAIN_MODEL_SVH

coef_t                   shadow_coef [CHANNELS];
coef_t                   active_coef [CHANNELS];
logic [SAMPLE_WIDTH-1:0] shadow_step [CHANNELS];
logic [SAMPLE_WIDTH-1:0] ramp_step   [CHANNELS];
logic [SAMPLE_WIDTH-1:0] ramp_acc    [CHANNELS];   // Sample 0 of the next ramp word
logic [CHANNELS-1:0]     shadow_ramp;
logic [CHANNELS-1:0]     ramp_mode;

chan_word_t expected_q [CHANNELS][$];   // External words still in flight

function automatic void reset_model();
  for (int ch = 0; ch < CHANNELS; ch++) begin
    shadow_coef[ch] = '{scale: 18'sd65536, offset: 14'sd0};   // Unity gain, no offset
    active_coef[ch] = shadow_coef[ch];
    shadow_step[ch] = '0;
    ramp_step[ch] = '0;
    ramp_acc[ch] = '0;
  end
  shadow_ramp = '0;
  ramp_mode = '0;
endfunction

// Bits 31..16 of x*scale + offset*2^20
function automatic sample_t scale_sample(sample_t x, coef_t c);
  longint product;
  longint total;
  product = longint'(x) * longint'(c.scale);
  total = product + longint'(c.offset) * 64'sd1048576;
  return sample_t'(total >>> 16);   // Wraps to 16 bits
endfunction

function automatic chan_word_t scale_word(chan_word_t w, coef_t c);
  chan_word_t r;
  for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
    r[k] = scale_sample(w[k], c);
  end
  return r;
endfunction

function automatic chan_word_t ramp_word(logic [SAMPLE_WIDTH-1:0] acc,
                                         logic [SAMPLE_WIDTH-1:0] step);
  chan_word_t r;
  for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
    r[k] = sample_t'(acc + 16'(k) * step);
  end
  return r;
endfunction

function automatic chan_word_t next_ramp_expected(int ch);
  chan_word_t r;
  r = scale_word(ramp_word(ramp_acc[ch], ramp_step[ch]), active_coef[ch]);
  ramp_acc[ch] = ramp_acc[ch] + ramp_step[ch] * 16'd4;   // One word further
  return r;
endfunction

function automatic void push_expected(stream_t s);
  for (int ch = 0; ch < CHANNELS; ch++) begin
    if (s.valid[ch] && !ramp_mode[ch]) begin
      expected_q[ch].push_back(scale_word(s.data[ch], active_coef[ch]));
    end
  end
endfunction

function automatic void apply_command(cmd_t c);
  case (c.op)
    CMD_SET_SCALE:  shadow_coef[c.channel].scale = c.value;
    CMD_SET_OFFSET: shadow_coef[c.channel].offset = c.value[OFFSET_WIDTH-1:0];
    CMD_SET_STEP:   shadow_step[c.channel] = c.value[SAMPLE_WIDTH-1:0];
    CMD_SET_SOURCE: shadow_ramp[c.channel] = c.value[0];
    CMD_COMMIT: begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        active_coef[ch] = shadow_coef[ch];
        ramp_step[ch] = shadow_step[ch];
        ramp_acc[ch] = '0;   // Ramp restarts at zero
      end
      ramp_mode = shadow_ramp;
    end
    default: ;
  endcase
endfunction

`endif

/* tests/dac_chain_tb.sv */
/* Seeded random test of the DAC output chain against a reference model.
   Commits are issued only after the stream has been idle for at least 8 cycles */
`timescale 1ns/1ps
`default_nettype none

module dac_chain_tb
  import dac_chain_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int SEED = 86205;
  localparam int N_UNITY = 300;
  localparam int N_GAIN = 400;
  localparam int N_SHADOW = 200;
  localparam int N_RAMP = 200;
  localparam int OVERHEAD_CYCLES = 200;   // Reset, commands and drains
  localparam int STIM_CYCLES = N_UNITY + N_GAIN + 2 * N_SHADOW + N_RAMP + OVERHEAD_CYCLES;

  logic    clk = 1'b0;
  logic    reset;
  logic    cmd_valid;
  cmd_t    cmd;
  stream_t in_stream;
  stream_t out_stream;

  string test_name;
  int    word_errors;
  int    valid_errors;
  int    other_errors;

  `include "dac_chain_model.svh"

  dac_output_chain dut (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .in_stream  (in_stream),
    .out_stream (out_stream)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_word(string name, int channel, chan_word_t expected,
                            chan_word_t actual);
    if (expected !== actual) begin
      $display("mismatch %s ch%0d: expected %h actual %h", name, channel, expected, actual);
      word_errors++;
    end
  endtask

  task automatic check_valid(string name, logic [CHANNELS-1:0] expected,
                             logic [CHANNELS-1:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s valid: expected %b actual %b", name, expected, actual);
      valid_errors++;
    end
  endtask

  function automatic sample_t random_sample(bit extremes);
    logic [1:0] pick;
    pick = 2'($urandom);
    if (extremes && ($urandom % 3 == 0)) begin
      case (pick)
        2'd0: return 16'sh7fff;   // Full scale overflows with gain
        2'd1: return 16'sh8000;
        2'd2: return 16'shffff;
        default: return 16'sh0001;
      endcase
    end
    return sample_t'($urandom);
  endfunction

  function automatic stream_t random_stream(bit extremes);
    stream_t s;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      s.valid[ch] = 1'($urandom);
      for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
        s.data[ch][k] = random_sample(extremes);
      end
    end
    return s;
  endfunction

  task automatic drive_cycle(stream_t s);
    @(posedge clk);
    #1;
    in_stream = s;
    push_expected(s);
  endtask

  task automatic idle_cycles(int n);
    repeat (n) drive_cycle('0);
  endtask

  task automatic send_cmd(cmd_op_t op, int channel, logic [SCALE_WIDTH-1:0] value);
    cmd_t c;
    c = '{op: op, channel: CHAN_SEL_WIDTH'(channel), value: value};
    @(posedge clk);
    #1;
    in_stream.valid = '0;
    cmd_valid = 1'b1;
    cmd = c;
    apply_command(c);
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd = '{op: CMD_NOP, channel: '0, value: '0};
  endtask

  task automatic commit_settings();
    idle_cycles(8);   // Nothing in flight when coefficients change
    send_cmd(CMD_COMMIT, 0, '0);
    idle_cycles(2);
  endtask

  task automatic set_random_coefs();
    for (int ch = 0; ch < CHANNELS; ch++) begin
      send_cmd(CMD_SET_SCALE, ch, 18'($urandom));
      send_cmd(CMD_SET_OFFSET, ch, 18'($urandom));
    end
  endtask

  task automatic run_traffic(string name, int n, bit extremes);
    test_name = name;
    repeat (n) drive_cycle(random_stream(extremes));
    idle_cycles(10);   // Drain the pipeline
  endtask

  // Output monitor samples away from the driving edge
  always @(negedge clk) begin
    chan_word_t expected;
    if (!reset) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (out_stream.valid[ch] === 1'b1) begin
          if (ramp_mode[ch]) begin
            expected = next_ramp_expected(ch);
            check_word(test_name, ch, expected, out_stream.data[ch]);
          end else if (expected_q[ch].size() == 0) begin
            $display("ERROR: channel %0d output a word that was never sent", ch);
            other_errors++;
          end else begin
            expected = expected_q[ch].pop_front();
            check_word(test_name, ch, expected, out_stream.data[ch]);
          end
        end
      end
    end
  end

  initial begin
    #((STIM_CYCLES + 200) * CLK_PERIOD);
    $display("ERROR: watchdog timeout, run exceeded %0d cycles", STIM_CYCLES + 200);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    stream_t             lone;
    int                  lone_ch;
    logic [CHANNELS-1:0] lone_mask;
    logic [CHANNELS-1:0] ramp_mask;
    int                  ramp_a;
    int                  ramp_b;
    void'($urandom(SEED));
    reset = 1'b1;
    cmd_valid = 1'b0;
    cmd = '{op: CMD_NOP, channel: '0, value: '0};
    in_stream = '0;
    word_errors = 0;
    valid_errors = 0;
    other_errors = 0;
    test_name = "reset";
    reset_model();
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_valid("reset", '0, out_stream.valid);
    end

    run_traffic("unity", N_UNITY, 1'b0);

    // A lone word must appear exactly six cycles later
    test_name = "latency";
    lone_ch = int'($urandom % CHANNELS);
    lone_mask = CHANNELS'(1 << lone_ch);
    lone = '0;
    lone.valid = lone_mask;
    for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
      lone.data[lone_ch][k] = random_sample(1'b1);
    end
    drive_cycle(lone);
    for (int k = 1; k <= 6; k++) begin
      drive_cycle('0);
      @(negedge clk);
      check_valid("latency", (k == 6) ? lone_mask : CHANNELS'(0), out_stream.valid);
    end
    idle_cycles(4);

    set_random_coefs();
    commit_settings();
    run_traffic("gain", N_GAIN, 1'b1);

    set_random_coefs();   // Shadow only until the commit
    run_traffic("shadow_old", N_SHADOW, 1'b1);
    commit_settings();
    run_traffic("shadow_new", N_SHADOW, 1'b1);

    ramp_a = int'($urandom % CHANNELS);
    ramp_b = (ramp_a + 1 + int'($urandom % (CHANNELS - 1))) % CHANNELS;
    ramp_mask = CHANNELS'((1 << ramp_a) | (1 << ramp_b));
    for (int ch = 0; ch < CHANNELS; ch++) begin
      send_cmd(CMD_SET_STEP, ch, 18'($urandom));
    end
    send_cmd(CMD_SET_SOURCE, ramp_a, 18'd1);
    send_cmd(CMD_SET_SOURCE, ramp_b, 18'd1);
    commit_settings();
    test_name = "ramp";
    idle_cycles(6);   // First ramp word reaches the output
    repeat (N_RAMP) begin
      drive_cycle(random_stream(1'b1));
      @(negedge clk);
      check_valid("ramp", ramp_mask, out_stream.valid & ramp_mask);
    end
    idle_cycles(10);

    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (expected_q[ch].size() != 0) begin
        $display("ERROR: channel %0d never output %0d expected words", ch,
                 expected_q[ch].size());
        other_errors++;
      end
    end
    $display("Summary: %0d word mismatches, %0d valid mismatches, %0d other errors",
             word_errors, valid_errors, other_errors);
    if (word_errors + valid_errors + other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/dac_chain_pkg.sv */
/* Channel count, word width and coefficient formats are fixed here for the whole chain.
   Scale is signed 2Q16 and offset is signed 2Q12, and all arithmetic wraps */
`default_nettype none

package dac_chain_pkg;

  localparam int CHANNELS = 4;
  localparam int PARALLEL_SAMPLES = 4;
  localparam int SAMPLE_WIDTH = 16;     // Signed 0Q16
  localparam int SCALE_WIDTH = 18;      // Signed 2Q16
  localparam int OFFSET_WIDTH = 14;     // Signed 2Q12
  localparam int INT_BITS = 2;

  localparam int SCALE_FRAC_BITS = SCALE_WIDTH - INT_BITS;
  localparam int OFFSET_FRAC_BITS = OFFSET_WIDTH - INT_BITS;
  localparam int CHAN_SEL_WIDTH = $clog2(CHANNELS);

  // Unity gain in 2Q16
  localparam logic [SCALE_WIDTH-1:0] SCALE_ONE = SCALE_WIDTH'(1 << SCALE_FRAC_BITS);

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // Index 0 holds the earliest sample
  typedef sample_t [PARALLEL_SAMPLES-1:0] chan_word_t;

  typedef struct packed {
    logic [CHANNELS-1:0]    valid;
    chan_word_t [CHANNELS-1:0] data;
  } stream_t;

  typedef struct packed {
    logic signed [SCALE_WIDTH-1:0]  scale;
    logic signed [OFFSET_WIDTH-1:0] offset;
  } coef_t;

  typedef struct packed {
    logic                 load;   // One-cycle pulse
    coef_t [CHANNELS-1:0] chan;
  } coef_load_t;

  typedef struct packed {
    logic                                  load;   // Pulses with coef_load_t.load
    logic [CHANNELS-1:0]                   use_ramp;
    logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] step;
  } source_cfg_t;

  typedef enum logic [2:0] {
    CMD_NOP        = 3'd0,
    CMD_SET_SCALE  = 3'd1,
    CMD_SET_OFFSET = 3'd2,
    CMD_SET_STEP   = 3'd3,
    CMD_SET_SOURCE = 3'd4,
    CMD_COMMIT     = 3'd5
  } cmd_op_t;

  typedef struct packed {
    cmd_op_t                   op;
    logic [CHAN_SEL_WIDTH-1:0] channel;
    logic [SCALE_WIDTH-1:0]    value;   // Low bits used for offset, step and source
  } cmd_t;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_LOAD = 1'b1
  } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/dac_cmd_ctrl.sv */
/* Commands are one-cycle strobes. Shadow values reach the datapath one cycle after a
   commit, and a commit that arrives during the load cycle is dropped */
`timescale 1ns/1ps
`default_nettype none

module dac_cmd_ctrl
  import dac_chain_pkg::*;
(
  input  wire         clk,
  input  wire         reset,
  input  wire         cmd_valid,
  input  wire cmd_t   cmd,
  output source_cfg_t src_cfg,
  output coef_load_t  coef
);

  ctrl_state_t state;

  coef_t [CHANNELS-1:0]                  shadow_coef;
  logic [CHANNELS-1:0]                   shadow_use_ramp;
  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] shadow_step;

  logic load;
  logic commit;

  assign commit = cmd_valid && (cmd.op == CMD_COMMIT);
  assign load = (state == ST_LOAD);

  // Commit FSM, one load cycle per accepted commit
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (commit) begin
            state <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          state <= ST_IDLE;   // Single load cycle
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Shadow registers, written at any time
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        shadow_coef[ch].scale <= SCALE_ONE;
        shadow_coef[ch].offset <= '0;
      end
      shadow_use_ramp <= '0;
      shadow_step <= '0;
    end else if (cmd_valid) begin
      case (cmd.op)
        CMD_SET_SCALE: begin
          shadow_coef[cmd.channel].scale <= cmd.value;
        end
        CMD_SET_OFFSET: begin
          shadow_coef[cmd.channel].offset <= cmd.value[OFFSET_WIDTH-1:0];
        end
        CMD_SET_STEP: begin
          shadow_step[cmd.channel] <= cmd.value[SAMPLE_WIDTH-1:0];
        end
        CMD_SET_SOURCE: begin
          shadow_use_ramp[cmd.channel] <= cmd.value[0];   // 1 selects ramp
        end
        default: begin
          // NOP and commit leave the shadow untouched
        end
      endcase
    end
  end

  // Both load bits come from the same state, so they always pulse together
  assign src_cfg = '{load: load, use_ramp: shadow_use_ramp, step: shadow_step};
  assign coef = '{load: load, chan: shadow_coef};

  a_load_single: assert property (@(posedge clk) disable iff (reset)
    coef.load |=> !coef.load)
    else $error("Load pulse held for two cycles, state %s", state.name());

  a_cmd_known: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |-> !$isunknown(cmd))
    else $error("Command word has X bits while cmd_valid is high");

endmodule

`default_nettype wire

/* verilog/dac_output_chain.sv */
/* Six cycles from in_stream to out_stream. New settings need a commit and apply to
   words entering after the load, so commit only while the stream is idle */
`timescale 1ns/1ps
`default_nettype none

module dac_output_chain
  import dac_chain_pkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  wire          cmd_valid,
  input  wire cmd_t    cmd,
  input  wire stream_t in_stream,
  output stream_t      out_stream
);

  source_cfg_t src_cfg;
  coef_load_t  coef;
  stream_t     scaled_in;   // Source output, prescaler input

  // Command decoder with shadow registers
  dac_cmd_ctrl u_cmd_ctrl (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .src_cfg   (src_cfg),
    .coef      (coef)
  );

  // External stream or test ramp, one cycle
  dac_ramp_source u_ramp_source (
    .clk        (clk),
    .reset      (reset),
    .src_cfg    (src_cfg),
    .in_stream  (in_stream),
    .out_stream (scaled_in)
  );

  // Gain and offset, five cycles
  dac_prescaler u_prescaler (
    .clk        (clk),
    .reset      (reset),
    .coef       (coef),
    .in_stream  (scaled_in),
    .out_stream (out_stream)
  );

endmodule

`default_nettype wire

/* verilog/dac_prescaler.sv */
/* Five cycles of latency with no back-pressure. Results wrap on overflow, and coefficients
   change under words already in flight */
`timescale 1ns/1ps
`default_nettype none

module dac_prescaler
  import dac_chain_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire coef_load_t coef,
  input  wire stream_t    in_stream,
  output stream_t         out_stream
);

  localparam int LATENCY = 5;
  localparam int PROD_WIDTH = SAMPLE_WIDTH + SCALE_WIDTH;   // 2Q32
  localparam int ALIGN_BITS = SAMPLE_WIDTH + SCALE_FRAC_BITS - OFFSET_FRAC_BITS;
  localparam int RESULT_MSB = SAMPLE_WIDTH + SCALE_FRAC_BITS - 1;

  // Active coefficients
  logic signed [SCALE_WIDTH-1:0]  scale_reg  [CHANNELS];
  logic signed [OFFSET_WIDTH-1:0] offset_reg [CHANNELS];

  sample_t                        data_in_reg [CHANNELS][PARALLEL_SAMPLES];  // 0Q16
  logic signed [PROD_WIDTH-1:0]   product     [CHANNELS][PARALLEL_SAMPLES];  // 2Q32
  logic signed [PROD_WIDTH:0]     sum         [CHANNELS][PARALLEL_SAMPLES];  // 3Q32
  sample_t                        sum_d       [CHANNELS][PARALLEL_SAMPLES];  // 0Q16
  chan_word_t [CHANNELS-1:0]      data_out_q;

  logic [CHANNELS-1:0][LATENCY-1:0] valid_d;
  logic [CHANNELS-1:0]              valid_out;

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (reset) begin
        scale_reg[ch] <= SCALE_ONE;
        offset_reg[ch] <= '0;
      end else if (coef.load) begin
        scale_reg[ch] <= coef.chan[ch].scale;
        offset_reg[ch] <= coef.chan[ch].offset;
      end
    end
  end

  // Input, product, offset sum, truncation, output
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int s = 0; s < PARALLEL_SAMPLES; s++) begin
        data_in_reg[ch][s] <= in_stream.data[ch][s];
        product[ch][s] <= data_in_reg[ch][s] * scale_reg[ch];
        sum[ch][s] <= product[ch][s]
                      + $signed({offset_reg[ch], {ALIGN_BITS{1'b0}}});   // 2Q12 to 2Q32
        sum_d[ch][s] <= sum[ch][s][RESULT_MSB -: SAMPLE_WIDTH];   // Drops int bits
        data_out_q[ch][s] <= sum_d[ch][s];
      end
    end
  end

  // Valid delay line matches the data stages
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_d <= '0;
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        valid_d[ch] <= {valid_d[ch][LATENCY-2:0], in_stream.valid[ch]};
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      valid_out[ch] = valid_d[ch][LATENCY-1];
    end
  end

  assign out_stream = '{valid: valid_out, data: data_out_q};

  a_valid_origin: assert property (@(posedge clk) disable iff (reset)
    (out_stream.valid & ~$past(in_stream.valid, LATENCY)) == '0)
    else $error("Prescaler valid without input valid %0d cycles earlier, 0x%h",
                LATENCY, out_stream.valid);

endmodule

`default_nettype wire

/* verilog/dac_ramp_source.sv */
/* One cycle of latency. Ramp channels are valid every cycle and restart from zero on each
   load, while external channels pass through with their own valid */
`timescale 1ns/1ps
`default_nettype none

module dac_ramp_source
  import dac_chain_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire source_cfg_t src_cfg,
  input  wire stream_t     in_stream,
  output stream_t          out_stream
);

  // Latched configuration
  logic [CHANNELS-1:0]                   use_ramp;
  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] step;

  // Ramp state, value of sample 0 of the next word
  logic [CHANNELS-1:0][SAMPLE_WIDTH-1:0] acc;

  chan_word_t [CHANNELS-1:0] ramp_word;
  chan_word_t [CHANNELS-1:0] data_q;
  logic [CHANNELS-1:0]       valid_q;

  // Four consecutive ramp samples per channel
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      for (int k = 0; k < PARALLEL_SAMPLES; k++) begin
        ramp_word[ch][k] = acc[ch] + step[ch] * SAMPLE_WIDTH'(k);   // Wraps at 16 bits
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      use_ramp <= '0;
      step <= '0;
      acc <= '0;
    end else if (src_cfg.load) begin
      use_ramp <= src_cfg.use_ramp;
      step <= src_cfg.step;
      acc <= '0;   // Ramp restarts at zero
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (use_ramp[ch]) begin
          acc[ch] <= acc[ch] + (step[ch] << 2);   // Advance by one word
        end
      end
    end
  end

  // Registered source mux
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      data_q[ch] <= use_ramp[ch] ? ramp_word[ch] : in_stream.data[ch];
    end
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= use_ramp | in_stream.valid;   // Ramp channels always valid
    end
  end

  assign out_stream = '{valid: valid_q, data: data_q};

  a_quiet_after_reset: assert property (@(posedge clk)
    reset |=> (out_stream.valid == '0))
    else $error("Source valid high in the cycle after reset, 0x%h", out_stream.valid);

endmodule

`default_nettype wire
